// ==== tb.f ====
logic/core_pkg.sv
logic/redirect_sel.sv
logic/mem_req_merge.sv
logic/regs_file.sv
logic/backend_top.sv
verification/backend_top_asserts.sv
verification/tb_backend_top.sv

// ==== Makefile ====
VERILATOR := verilator
FLAGS     := --binary --timing --assert
TOP       := tb_backend_top
FILELIST  := tb.f
BUILD_DIR := obj_dir
SIM_ARGS  := +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only --timing --assert --top-module $(TOP) -f $(FILELIST)

sim:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(SIM_ARGS) | tee /dev/stderr | grep -q "TEST OK"

clean:
	rm -rf $(BUILD_DIR)

// ==== verification/tb_backend_top.sv ====
module tb_backend_top;
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    localparam int READ_PORTS = 4;
    localparam int MAX_CYCLES = 2000;  // About three times the test length

    logic clk, rst_i;
    logic excp_flush_i, tlbrefill_i, ertn_flush_i, idle_flush_i, fetch_flush_i, ex_stall_i;
    word_t eentry_i, tlbrentry_i, era_i, idle_pc_i;
    ftq_id_t ctrl_ftq_id_i, redirect_ftq_id_o;
    logic [LANES-1:0] branch_i, lane_ce_i, lane_we_i, wb_flush_i, wb_we_i;
    word_t [LANES-1:0] branch_target_i, lane_addr_i, lane_wdata_i, wb_wdata_i, wb_pc_i;
    ftq_id_t [LANES-1:0] branch_ftq_id_i;
    byte_sel_t [LANES-1:0] lane_sel_i;
    access_type_t [LANES-1:0] lane_rd_type_i, lane_wr_type_i;
    reg_addr_t [LANES-1:0] wb_waddr_i, dbg_wnum_o;
    word_t [LANES-1:0] dbg_pc_o, dbg_wdata_o;
    logic [LANES-1:0][3:0] dbg_wen_o;
    logic redirect_o, dc_valid_o, dc_we_o, dc_flush_o;
    word_t next_pc_o, dc_addr_o, dc_wdata_o;
    byte_sel_t dc_sel_o;
    access_type_t dc_rd_type_o, dc_wr_type_o;
    logic [READ_PORTS-1:0] read_valid_i;
    reg_addr_t [READ_PORTS-1:0] read_addr_i;
    word_t [READ_PORTS-1:0] read_data_o;

    int seed = 32'h5205;
    int cycles = 0;
    int tests_run = 0;

    backend_top #(.READ_PORTS(READ_PORTS)) i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) cycles <= cycles + 1;

    function automatic word_t rand_word();
        rand_word = $random(seed);
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #2;  // Drive away from the sampling edge
    endtask

    task automatic clear_inputs();
        {excp_flush_i, tlbrefill_i, ertn_flush_i, idle_flush_i, fetch_flush_i} = '0;
        ex_stall_i = 1'b0;
        {eentry_i, tlbrentry_i, era_i, idle_pc_i, ctrl_ftq_id_i} = '0;
        {branch_i, branch_target_i, branch_ftq_id_i} = '0;
        {lane_ce_i, lane_we_i, lane_sel_i, lane_rd_type_i, lane_wr_type_i} = '0;
        {lane_addr_i, lane_wdata_i, wb_flush_i} = '0;
        {wb_we_i, wb_waddr_i, wb_wdata_i, wb_pc_i} = '0;
        {read_valid_i, read_addr_i} = '0;
    endtask

    function automatic void report(string name);
        tests_run++;
        $display("%s finished, assertion failures so far %0d", name, i_dut.u_asserts.fail_cnt);
    endfunction

    // All 256 mixes of the six flush levels and two branch lanes
    task automatic redirect_priority();
        word_t r;
        for (int i = 0; i < 256; i++) begin
            {excp_flush_i, tlbrefill_i, ertn_flush_i, idle_flush_i} = i[7:4];
            {fetch_flush_i, ex_stall_i, branch_i} = i[3:0];
            eentry_i        = rand_word();
            tlbrentry_i     = rand_word();
            era_i           = rand_word();
            idle_pc_i       = rand_word();
            r               = rand_word();
            ctrl_ftq_id_i   = r[2:0];
            branch_ftq_id_i = r[8:3];
            branch_target_i = {rand_word(), rand_word()};
            next_cycle();
        end
        clear_inputs();
        next_cycle();
        next_cycle();
        report("redirect priority");
    endtask

    task automatic merge_requests();
        word_t r;
        for (int i = 0; i < 200; i++) begin
            r              = rand_word();
            lane_ce_i      = r[1:0];  // Both idle about one cycle in four
            lane_we_i      = r[3:2];
            wb_flush_i     = r[5:4];
            lane_sel_i     = r[13:6];
            lane_rd_type_i = r[19:14];
            lane_wr_type_i = r[25:20];
            lane_addr_i    = {rand_word(), rand_word()};
            lane_wdata_i   = {rand_word(), rand_word()};
            next_cycle();
        end
        clear_inputs();
        next_cycle();
        next_cycle();
        report("memory request merge");
    endtask

    task automatic random_writeback(int count);
        word_t r;
        word_t r2;
        for (int i = 0; i < count; i++) begin
            r            = rand_word();
            r2           = rand_word();
            wb_we_i      = r[1:0];
            wb_waddr_i   = r[11:2];
            read_valid_i = r[15:12];
            read_addr_i  = r2[19:0];
            wb_wdata_i   = {rand_word(), rand_word()};
            wb_pc_i      = {rand_word(), rand_word()};
            next_cycle();
        end
    endtask

    task automatic regfile_access();
        reg_addr_t addr;
        addr = 5'd1;
        repeat (16) begin  // Fill every register, last lane 1 write hits r0
            wb_we_i    = 2'b11;
            wb_waddr_i = {addr + 5'd1, addr};
            wb_wdata_i = {rand_word(), rand_word()};
            addr       = addr + 5'd2;
            next_cycle();
        end
        random_writeback(120);
        wb_we_i      = 2'b11;  // Same register on both lanes
        wb_waddr_i   = {5'd7, 5'd7};
        wb_wdata_i   = {rand_word(), rand_word()};
        read_valid_i = '1;
        read_addr_i  = {5'd7, 5'd7, 5'd7, 5'd7};
        next_cycle();
        wb_we_i      = 2'b01;
        wb_waddr_i   = '0;
        wb_wdata_i   = {rand_word(), rand_word()};
        next_cycle();
        wb_we_i      = 2'b00;
        read_addr_i  = {5'd0, 5'd0, 5'd7, 5'd0};
        next_cycle();
        read_valid_i = '0;
        read_addr_i  = {5'd3, 5'd9, 5'd17, 5'd31};
        next_cycle();
        clear_inputs();
        next_cycle();
        report("register file");
    endtask

    initial begin
        clear_inputs();
        rst_i = 1'b1;
        repeat (16) @(posedge clk);
        #2;
        rst_i = 1'b0;
        next_cycle();
        report("reset state");
        redirect_priority();
        merge_requests();
        regfile_access();
        random_writeback(40);
        clear_inputs();
        next_cycle();
        next_cycle();
        report("commit trace");
        $display("Tests run %0d, assertion failures %0d", tests_run, i_dut.u_asserts.fail_cnt);
        if (i_dut.u_asserts.fail_cnt == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

    initial begin
        wait (cycles >= MAX_CYCLES);
        $display("Timeout, the run did not finish within %0d cycles", MAX_CYCLES);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== verification/backend_top_asserts.sv ====
module backend_top_asserts #(
    parameter int READ_PORTS = 4
) (
    input logic clk, rst_i,
    input logic excp_flush_i, tlbrefill_i, ertn_flush_i,
    input logic idle_flush_i, fetch_flush_i, ex_stall_i,
    input core_pkg::word_t eentry_i, tlbrentry_i, era_i, idle_pc_i,
    input core_pkg::ftq_id_t ctrl_ftq_id_i,
    input logic [core_pkg::LANES-1:0] branch_i, lane_ce_i, lane_we_i, wb_flush_i, wb_we_i,
    input core_pkg::word_t [core_pkg::LANES-1:0] branch_target_i, lane_addr_i, lane_wdata_i,
    input core_pkg::word_t [core_pkg::LANES-1:0] wb_wdata_i, wb_pc_i, dbg_pc_o, dbg_wdata_o,
    input core_pkg::ftq_id_t [core_pkg::LANES-1:0] branch_ftq_id_i,
    input core_pkg::byte_sel_t [core_pkg::LANES-1:0] lane_sel_i,
    input core_pkg::access_type_t [core_pkg::LANES-1:0] lane_rd_type_i, lane_wr_type_i,
    input core_pkg::reg_addr_t [core_pkg::LANES-1:0] wb_waddr_i, dbg_wnum_o,
    input logic [core_pkg::LANES-1:0][3:0] dbg_wen_o,
    input logic redirect_o, dc_valid_o, dc_we_o, dc_flush_o,
    input core_pkg::word_t next_pc_o, dc_addr_o, dc_wdata_o,
    input core_pkg::ftq_id_t redirect_ftq_id_o,
    input core_pkg::byte_sel_t dc_sel_o,
    input core_pkg::access_type_t dc_rd_type_o, dc_wr_type_o,
    input logic [READ_PORTS-1:0] read_valid_i,
    input core_pkg::reg_addr_t [READ_PORTS-1:0] read_addr_i,
    input core_pkg::word_t [READ_PORTS-1:0] read_data_o
);
    timeunit 1ns;
    timeprecision 100ps;
    import core_pkg::*;

    int           fail_cnt = 0;
    logic         exp_rd, exp_rd_q, mreq_lane, rf_ok;
    logic [2:0]   exp_strb_q;  // Valid, write and flush
    word_t        exp_pc, exp_pc_q, exp_addr_q, exp_wdata_q;
    ftq_id_t      exp_id, exp_id_q;
    byte_sel_t    exp_sel_q;
    access_type_t exp_rdt_q, exp_wrt_q;
    word_t        model [32];  // Shadow register file
    word_t        port_exp, rf_exp, rf_got;
    int           rf_port;
    word_t [LANES-1:0]     exp_dbg_pc_q, exp_dbg_wdata_q;
    reg_addr_t [LANES-1:0] exp_dbg_wnum_q;
    logic [LANES-1:0][3:0] exp_dbg_wen_q;

    // Expected redirect, highest priority first
    always_comb begin
        exp_rd = 1'b1;
        exp_id = ctrl_ftq_id_i;
        exp_pc = '0;
        if (excp_flush_i && tlbrefill_i) exp_pc = tlbrentry_i;
        else if (excp_flush_i) exp_pc = eentry_i;
        else if (ertn_flush_i) exp_pc = era_i;
        else if (idle_flush_i) exp_pc = idle_pc_i;
        else if (fetch_flush_i) exp_pc = idle_pc_i + 32'd4;
        else if (ex_stall_i || branch_i == '0) begin
            exp_rd = 1'b0;
            exp_id = '0;
        end else if (branch_i[0]) begin
            exp_pc = branch_target_i[0];
            exp_id = branch_ftq_id_i[0];
        end else begin
            exp_pc = branch_target_i[1];
            exp_id = branch_ftq_id_i[1];
        end
    end

    assign mreq_lane = lane_ce_i[0] ? 1'b0 : 1'b1;

    always @(posedge clk) begin
        exp_rd_q    <= exp_rd;
        exp_pc_q    <= exp_pc;
        exp_id_q    <= exp_id;
        exp_strb_q  <= {|lane_ce_i, |lane_we_i, |wb_flush_i};
        exp_addr_q  <= (lane_ce_i != '0) ? lane_addr_i[mreq_lane] : '0;
        exp_sel_q   <= (lane_ce_i != '0) ? lane_sel_i[mreq_lane] : '0;
        exp_rdt_q   <= (lane_ce_i != '0) ? lane_rd_type_i[mreq_lane] : '0;
        exp_wrt_q   <= (lane_ce_i != '0) ? lane_wr_type_i[mreq_lane] : '0;
        exp_wdata_q <= (lane_ce_i == '0) ? '0
                     : (lane_we_i[0] ? lane_wdata_i[0] : lane_wdata_i[1]);
        exp_dbg_pc_q    <= wb_pc_i;
        exp_dbg_wdata_q <= wb_wdata_i;
        exp_dbg_wnum_q  <= wb_waddr_i;
        for (int i = 0; i < LANES; i++) begin
            exp_dbg_wen_q[i] <= {3'b000, wb_we_i[i]};  // Enable in bit 0 only
            if (wb_we_i[i] && wb_waddr_i[i] != '0) model[wb_waddr_i[i]] <= wb_wdata_i[i];
        end
    end

    // First mismatching read port, if any
    always_comb begin
        rf_ok   = 1'b1;
        rf_port = 0;
        rf_exp  = '0;
        rf_got  = '0;
        for (int p = 0; p < READ_PORTS; p++) begin
            port_exp = (read_valid_i[p] && read_addr_i[p] != '0) ? model[read_addr_i[p]] : '0;
            if (rf_ok && read_data_o[p] != port_exp) begin
                rf_ok   = 1'b0;
                rf_port = p;
                rf_exp  = port_exp;
                rf_got  = read_data_o[p];
            end
        end
    end

    a_reset: assert property (@(posedge clk) rst_i |=> !redirect_o && !dc_valid_o && !dc_we_o
                              && !dc_flush_o && dbg_wen_o == '0)
    else begin
        $error("[ERROR] reset redirect_o %h dc_valid_o %h dc_we_o %h dc_flush_o %h dbg_wen_o %h",
               redirect_o, dc_valid_o, dc_we_o, dc_flush_o, dbg_wen_o);
        fail_cnt++;
    end

    a_redirect: assert property (@(posedge clk) disable iff (rst_i)
                                 redirect_o == exp_rd_q && redirect_ftq_id_o == exp_id_q)
    else begin
        $error("[ERROR] redirect_o exp %h got %h, redirect_ftq_id_o exp %h got %h",
               exp_rd_q, redirect_o, exp_id_q, redirect_ftq_id_o);
        fail_cnt++;
    end

    a_next_pc: assert property (@(posedge clk) disable iff (rst_i) next_pc_o == exp_pc_q)
    else begin
        $error("[ERROR] next_pc_o exp %h got %h", exp_pc_q, next_pc_o);
        fail_cnt++;
    end

    a_dc_strobes: assert property (@(posedge clk) disable iff (rst_i)
        {dc_valid_o, dc_we_o, dc_flush_o} == exp_strb_q)
    else begin
        $error("[ERROR] dc_valid_o/dc_we_o/dc_flush_o exp %h got %h",
               exp_strb_q, {dc_valid_o, dc_we_o, dc_flush_o});
        fail_cnt++;
    end

    a_dc_fields: assert property (@(posedge clk) disable iff (rst_i)
        dc_addr_o == exp_addr_q && dc_sel_o == exp_sel_q && dc_wdata_o == exp_wdata_q)
    else begin
        $error("[ERROR] dc_addr_o exp %h got %h, dc_wdata_o exp %h got %h, dc_sel_o exp %h got %h",
               exp_addr_q, dc_addr_o, exp_wdata_q, dc_wdata_o, exp_sel_q, dc_sel_o);
        fail_cnt++;
    end

    a_dc_types: assert property (@(posedge clk) disable iff (rst_i)
        dc_rd_type_o == exp_rdt_q && dc_wr_type_o == exp_wrt_q)
    else begin
        $error("[ERROR] dc_rd_type_o exp %h got %h, dc_wr_type_o exp %h got %h",
               exp_rdt_q, dc_rd_type_o, exp_wrt_q, dc_wr_type_o);
        fail_cnt++;
    end

    a_regfile: assert property (@(posedge clk) disable iff (rst_i) rf_ok)
    else begin
        $error("[ERROR] read_data_o[%0d] exp %h got %h", rf_port, rf_exp, rf_got);
        fail_cnt++;
    end

    a_trace_data: assert property (@(posedge clk) disable iff (rst_i)
        dbg_pc_o == exp_dbg_pc_q && dbg_wdata_o == exp_dbg_wdata_q)
    else begin
        $error("[ERROR] dbg_pc_o exp %h got %h, dbg_wdata_o exp %h got %h",
               exp_dbg_pc_q, dbg_pc_o, exp_dbg_wdata_q, dbg_wdata_o);
        fail_cnt++;
    end

    a_trace_wen: assert property (@(posedge clk) disable iff (rst_i)
        dbg_wnum_o == exp_dbg_wnum_q && dbg_wen_o == exp_dbg_wen_q)
    else begin
        $error("[ERROR] dbg_wnum_o exp %h got %h, dbg_wen_o exp %h got %h",
               exp_dbg_wnum_q, dbg_wnum_o, exp_dbg_wen_q, dbg_wen_o);
        fail_cnt++;
    end

endmodule

bind backend_top backend_top_asserts #(.READ_PORTS(READ_PORTS)) u_asserts (.*);

// ==== logic/backend_top.sv ====
module backend_top #(
    parameter int READ_PORTS = 4
) (
    input  logic                                         clk,
    input  logic                                         rst_i,

    // Redirect sources
    input  logic                                         excp_flush_i,
    input  logic                                         tlbrefill_i,
    input  logic                                         ertn_flush_i,
    input  logic                                         idle_flush_i,
    input  logic                                         fetch_flush_i,
    input  logic                                         ex_stall_i,
    input  core_pkg::word_t                              eentry_i,
    input  core_pkg::word_t                              tlbrentry_i,
    input  core_pkg::word_t                              era_i,
    input  core_pkg::word_t                              idle_pc_i,
    input  core_pkg::ftq_id_t                            ctrl_ftq_id_i,
    input  logic [core_pkg::LANES-1:0]                   branch_i,
    input  core_pkg::word_t [core_pkg::LANES-1:0]        branch_target_i,
    input  core_pkg::ftq_id_t [core_pkg::LANES-1:0]      branch_ftq_id_i,
    output logic                                         redirect_o,
    output core_pkg::word_t                              next_pc_o,
    output core_pkg::ftq_id_t                            redirect_ftq_id_o,

    // Memory lanes to data cache
    input  logic [core_pkg::LANES-1:0]                   lane_ce_i,
    input  logic [core_pkg::LANES-1:0]                   lane_we_i,
    input  core_pkg::byte_sel_t [core_pkg::LANES-1:0]    lane_sel_i,
    input  core_pkg::access_type_t [core_pkg::LANES-1:0] lane_rd_type_i,
    input  core_pkg::access_type_t [core_pkg::LANES-1:0] lane_wr_type_i,
    input  core_pkg::word_t [core_pkg::LANES-1:0]        lane_addr_i,
    input  core_pkg::word_t [core_pkg::LANES-1:0]        lane_wdata_i,
    input  logic [core_pkg::LANES-1:0]                   wb_flush_i,
    output logic                                         dc_valid_o,
    output logic                                         dc_we_o,
    output logic                                         dc_flush_o,
    output core_pkg::byte_sel_t                          dc_sel_o,
    output core_pkg::access_type_t                       dc_rd_type_o,
    output core_pkg::access_type_t                       dc_wr_type_o,
    output core_pkg::word_t                              dc_addr_o,
    output core_pkg::word_t                              dc_wdata_o,

    // Write-back lanes
    input  logic [core_pkg::LANES-1:0]                   wb_we_i,
    input  core_pkg::reg_addr_t [core_pkg::LANES-1:0]    wb_waddr_i,
    input  core_pkg::word_t [core_pkg::LANES-1:0]        wb_wdata_i,
    input  core_pkg::word_t [core_pkg::LANES-1:0]        wb_pc_i,

    // Dispatch read ports
    input  logic [READ_PORTS-1:0]                        read_valid_i,
    input  core_pkg::reg_addr_t [READ_PORTS-1:0]         read_addr_i,
    output core_pkg::word_t [READ_PORTS-1:0]             read_data_o,

    // Commit trace, one record per lane
    output core_pkg::word_t [core_pkg::LANES-1:0]        dbg_pc_o,
    output core_pkg::word_t [core_pkg::LANES-1:0]        dbg_wdata_o,
    output logic [core_pkg::LANES-1:0][3:0]              dbg_wen_o,
    output core_pkg::reg_addr_t [core_pkg::LANES-1:0]    dbg_wnum_o
);

    import core_pkg::*;

    redirect_sel u_redirect (
        .clk              (clk),
        .rst_i            (rst_i),
        .excp_flush_i     (excp_flush_i),
        .tlbrefill_i      (tlbrefill_i),
        .ertn_flush_i     (ertn_flush_i),
        .idle_flush_i     (idle_flush_i),
        .fetch_flush_i    (fetch_flush_i),
        .ex_stall_i       (ex_stall_i),
        .eentry_i         (eentry_i),
        .tlbrentry_i      (tlbrentry_i),
        .era_i            (era_i),
        .idle_pc_i        (idle_pc_i),
        .ctrl_ftq_id_i    (ctrl_ftq_id_i),
        .branch_i         (branch_i),
        .branch_target_i  (branch_target_i),
        .branch_ftq_id_i  (branch_ftq_id_i),
        .redirect_o       (redirect_o),
        .next_pc_o        (next_pc_o),
        .redirect_ftq_id_o(redirect_ftq_id_o)
    );

    mem_req_merge u_mem_merge (
        .clk           (clk),
        .rst_i         (rst_i),
        .lane_ce_i     (lane_ce_i),
        .lane_we_i     (lane_we_i),
        .lane_sel_i    (lane_sel_i),
        .lane_rd_type_i(lane_rd_type_i),
        .lane_wr_type_i(lane_wr_type_i),
        .lane_addr_i   (lane_addr_i),
        .lane_wdata_i  (lane_wdata_i),
        .wb_flush_i    (wb_flush_i),
        .dc_valid_o    (dc_valid_o),
        .dc_we_o       (dc_we_o),
        .dc_flush_o    (dc_flush_o),
        .dc_sel_o      (dc_sel_o),
        .dc_rd_type_o  (dc_rd_type_o),
        .dc_wr_type_o  (dc_wr_type_o),
        .dc_addr_o     (dc_addr_o),
        .dc_wdata_o    (dc_wdata_o)
    );

    regs_file #(
        .READ_PORTS(READ_PORTS)
    ) u_regfile (
        .clk         (clk),
        .we_i        (wb_we_i),
        .waddr_i     (wb_waddr_i),
        .wdata_i     (wb_wdata_i),
        .read_valid_i(read_valid_i),
        .read_addr_i (read_addr_i),
        .read_data_o (read_data_o)
    );

    // Commit record lags write-back by one cycle
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (rst_i) dbg_wen_o[i] <= '0;
            else dbg_wen_o[i] <= {3'b000, wb_we_i[i]};  // Only bit 0 is used
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            dbg_pc_o[i]    <= wb_pc_i[i];
            dbg_wdata_o[i] <= wb_wdata_i[i];
            dbg_wnum_o[i]  <= wb_waddr_i[i];
        end
    end

endmodule

// ==== logic/regs_file.sv ====
module regs_file #(
    parameter int READ_PORTS = 4
) (
    input  logic                                     clk,

    // Write-back lanes, lane 1 is the younger one
    input  logic [core_pkg::LANES-1:0]               we_i,
    input  core_pkg::reg_addr_t [core_pkg::LANES-1:0] waddr_i,
    input  core_pkg::word_t [core_pkg::LANES-1:0]    wdata_i,

    input  logic [READ_PORTS-1:0]                    read_valid_i,
    input  core_pkg::reg_addr_t [READ_PORTS-1:0]     read_addr_i,
    output core_pkg::word_t [READ_PORTS-1:0]         read_data_o
);

    import core_pkg::*;

    word_t regs [31:1];  // r0 is hardwired, no storage

    // Later lane assigned last, so it wins a same-register write
    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            if (we_i[i] && (waddr_i[i] != '0)) begin
                regs[waddr_i[i]] <= wdata_i[i];
            end
        end
    end

    // No write bypass, a same-cycle read sees the old value
    always_comb begin
        for (int p = 0; p < READ_PORTS; p++) begin
            if (!read_valid_i[p] || (read_addr_i[p] == '0)) begin
                read_data_o[p] = '0;
            end else begin
                read_data_o[p] = regs[read_addr_i[p]];
            end
        end
    end

endmodule

// ==== logic/mem_req_merge.sv ====
module mem_req_merge (
    input  logic                                         clk,
    input  logic                                         rst_i,

    input  logic [core_pkg::LANES-1:0]                   lane_ce_i,
    input  logic [core_pkg::LANES-1:0]                   lane_we_i,
    input  core_pkg::byte_sel_t [core_pkg::LANES-1:0]    lane_sel_i,
    input  core_pkg::access_type_t [core_pkg::LANES-1:0] lane_rd_type_i,
    input  core_pkg::access_type_t [core_pkg::LANES-1:0] lane_wr_type_i,
    input  core_pkg::word_t [core_pkg::LANES-1:0]        lane_addr_i,
    input  core_pkg::word_t [core_pkg::LANES-1:0]        lane_wdata_i,
    input  logic [core_pkg::LANES-1:0]                   wb_flush_i,

    output logic                                         dc_valid_o,
    output logic                                         dc_we_o,
    output logic                                         dc_flush_o,
    output core_pkg::byte_sel_t                          dc_sel_o,
    output core_pkg::access_type_t                       dc_rd_type_o,
    output core_pkg::access_type_t                       dc_wr_type_o,
    output core_pkg::word_t                              dc_addr_o,
    output core_pkg::word_t                              dc_wdata_o
);

    import core_pkg::*;

    logic src_lane;  // Lane that owns the request fields
    logic any_ce;

    assign any_ce   = |lane_ce_i;
    assign src_lane = ~lane_ce_i[0];

    always_ff @(posedge clk) begin
        if (rst_i) begin
            dc_valid_o <= 1'b0;
            dc_we_o    <= 1'b0;
            dc_flush_o <= 1'b0;
        end else begin
            dc_valid_o <= any_ce;
            dc_we_o    <= |lane_we_i;
            dc_flush_o <= |wb_flush_i;  // Either lane hit an exception
        end
    end

    // Lane 0 is older, so it owns the shared port
    always_ff @(posedge clk) begin
        dc_sel_o     <= any_ce ? lane_sel_i[src_lane] : '0;
        dc_rd_type_o <= any_ce ? lane_rd_type_i[src_lane] : '0;
        dc_wr_type_o <= any_ce ? lane_wr_type_i[src_lane] : '0;
        dc_addr_o    <= any_ce ? lane_addr_i[src_lane] : '0;
        if (!any_ce) dc_wdata_o <= '0;
        else if (lane_we_i[0]) dc_wdata_o <= lane_wdata_i[0];
        else dc_wdata_o <= lane_wdata_i[1];
    end

endmodule

// ==== logic/redirect_sel.sv ====
module redirect_sel (
    input  logic                                    clk,
    input  logic                                    rst_i,

    input  logic                                    excp_flush_i,
    input  logic                                    tlbrefill_i,
    input  logic                                    ertn_flush_i,
    input  logic                                    idle_flush_i,
    input  logic                                    fetch_flush_i,
    input  logic                                    ex_stall_i,

    input  core_pkg::word_t                         eentry_i,
    input  core_pkg::word_t                         tlbrentry_i,
    input  core_pkg::word_t                         era_i,
    input  core_pkg::word_t                         idle_pc_i,
    input  core_pkg::ftq_id_t                       ctrl_ftq_id_i,

    input  logic [core_pkg::LANES-1:0]              branch_i,
    input  core_pkg::word_t [core_pkg::LANES-1:0]   branch_target_i,
    input  core_pkg::ftq_id_t [core_pkg::LANES-1:0] branch_ftq_id_i,

    output logic                                    redirect_o,
    output core_pkg::word_t                         next_pc_o,
    output core_pkg::ftq_id_t                       redirect_ftq_id_o
);

    import core_pkg::*;

    logic [LANES-1:0] branch_ok;  // Branch flag may be stale while EX stalls
    logic             sel_valid;
    word_t            sel_pc;
    ftq_id_t          sel_ftq_id;

    assign branch_ok = branch_i & {LANES{~ex_stall_i}};

    // Fixed priority, exception first and lane 1 branch last
    always_comb begin
        sel_valid  = 1'b1;
        sel_pc     = '0;
        sel_ftq_id = ctrl_ftq_id_i;
        if (excp_flush_i) begin
            sel_pc = tlbrefill_i ? tlbrentry_i : eentry_i;
        end else if (ertn_flush_i) begin
            sel_pc = era_i;
        end else if (idle_flush_i) begin
            sel_pc = idle_pc_i;
        end else if (fetch_flush_i) begin
            sel_pc = idle_pc_i + 32'd4;  // Re-fetch the next instruction
        end else if (branch_ok[0]) begin
            sel_pc     = branch_target_i[0];
            sel_ftq_id = branch_ftq_id_i[0];
        end else if (branch_ok[1]) begin
            sel_pc     = branch_target_i[1];
            sel_ftq_id = branch_ftq_id_i[1];
        end else begin
            sel_valid  = 1'b0;
            sel_ftq_id = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst_i) begin
            redirect_o <= 1'b0;
        end else begin
            redirect_o <= sel_valid;  // One-cycle strobe per request
        end
    end

    always_ff @(posedge clk) begin
        next_pc_o         <= sel_pc;
        redirect_ftq_id_o <= sel_ftq_id;
    end

endmodule

// ==== logic/core_pkg.sv ====
package core_pkg;

    // Issue width of the back end
    localparam int LANES = 2;

    // Fetch queue entries seen by the redirect path
    localparam int FTQ_DEPTH = 8;

    // Data word, also used for every address
    typedef logic [31:0] word_t;

    // General register number
    typedef logic [4:0] reg_addr_t;

    typedef logic [$clog2(FTQ_DEPTH)-1:0] ftq_id_t;  // Fetch queue entry id

    // Per-byte write enable of one word
    typedef logic [3:0] byte_sel_t;

    typedef logic [2:0] access_type_t;  // Load/store size code, cache decodes it

endpackage
